// ==== include/riscv_defs.svh ====
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// ==========================================================================
// Core widths
// ==========================================================================

// Data and address width, RV32
`define XLEN 32

// Register index width, x0..x31
`define REG_AW 5

// ==========================================================================
// Fetch
// ==========================================================================

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/riscvPkg.sv ====
`include "riscv_defs.svh"

package riscvPkg;

  // ========================================================================
  // Encodings
  // ========================================================================

  // Kept RV32I major opcodes
  typedef enum logic [6:0] {
    opNop    = 7'b0000000, // All-zero word, bubble after reset
    opLoad   = 7'b0000011, // lw
    opIType  = 7'b0010011, // addi andi ori slti
    opStore  = 7'b0100011, // sw
    opRType  = 7'b0110011, // add sub and or slt
    opBranch = 7'b1100011, // beq
    opJal    = 7'b1101111
  } opcodeE;

  // Main decoder's ALU class
  typedef enum logic [1:0] {
    aluAdd   = 2'b00, // Address calc
    aluSub   = 2'b01, // beq compare
    aluFunct = 2'b10  // Look at funct3/funct7
  } aluOpE;

  // Sub and slt run the adder as a subtractor
  typedef enum logic [2:0] {
    ctlAdd = 3'b000,
    ctlSub = 3'b001,
    ctlAnd = 3'b010,
    ctlOr  = 3'b011,
    ctlSlt = 3'b101
  } aluCtrlE;

  typedef enum logic [1:0] {
    immI = 2'b00,
    immS = 2'b01,
    immB = 2'b10,
    immJ = 2'b11
  } immSrcE;

  typedef enum logic [1:0] {
    resAlu = 2'b00,
    resMem = 2'b01,
    resPc4 = 2'b10  // Link value for jal
  } resultSrcE;

  // Execute operand source
  typedef enum logic [1:0] {
    fwdNone = 2'b00, // Register file value
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSelE;

  // ========================================================================
  // Bundles
  // ========================================================================

  // Decode to execute control
  typedef struct packed {
    logic      regWrite;
    resultSrcE resultSrc;
    logic      memWrite;
    logic      jump;
    logic      branch;
    aluCtrlE   aluCtrl;
    logic      aluSrc;    // B operand from immediate
  } ctrlT;

  // Register indices seen by the hazard logic
  typedef struct packed {
    logic [`REG_AW-1:0] rs1D;
    logic [`REG_AW-1:0] rs2D;
    logic [`REG_AW-1:0] rs1E;
    logic [`REG_AW-1:0] rs2E;
    logic [`REG_AW-1:0] rdE;
    logic [`REG_AW-1:0] rdM;
    logic [`REG_AW-1:0] rdW;
  } regIdsT;

  typedef struct packed {
    logic   stallF;
    logic   stallD;
    logic   flushD;
    logic   flushE;
    fwdSelE fwdA;
    fwdSelE fwdB;
  } hazCtrlT;

  // Data memory request, write lands on the rising edge
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic             write;
  } dataBusT;

endpackage

// ==== hdl/intAlu.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module intAlu (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  riscvPkg::aluCtrlE aluCtrl,
  output logic [`XLEN-1:0] result,
  output logic             zero
);
  logic             subOp;
  logic [`XLEN-1:0] condInvB;
  logic [`XLEN-1:0] sum;
  logic             overflow;

  // One adder, sub as a + ~b + 1
  assign subOp    = (aluCtrl == riscvPkg::ctlSub) || (aluCtrl == riscvPkg::ctlSlt);
  assign condInvB = subOp ? ~b : b;
  assign sum      = a + condInvB + {{(`XLEN-1){1'b0}}, subOp};

  // Signed overflow, operands alike in sign but sum differs
  assign overflow = (a[`XLEN-1] ~^ condInvB[`XLEN-1]) & (a[`XLEN-1] ^ sum[`XLEN-1]);

  always_comb begin
    case (aluCtrl)
      riscvPkg::ctlAnd: result = a & b;
      riscvPkg::ctlOr:  result = a | b;
      riscvPkg::ctlSlt: result = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ overflow};
      default:          result = sum;       // add, sub
    endcase
  end

  assign zero = (result == '0);             // beq equal test

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module regFile (
  input  logic               clk,
  input  logic               we,
  input  logic [`REG_AW-1:0] ra1,
  input  logic [`REG_AW-1:0] ra2,
  input  logic [`REG_AW-1:0] wa,
  input  logic [`XLEN-1:0]   wd,
  output logic [`XLEN-1:0]   rd1,
  output logic [`XLEN-1:0]   rd2
);
  logic [`XLEN-1:0] regs [0:(1 << `REG_AW) - 1];

  // Falling edge write, so decode reads the value in the same cycle
  always_ff @(negedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1]; // x0 hardwired
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  // Writeback mux must hand over a defined value
  wdKnown: assert property (@(negedge clk) we |-> !$isunknown(wd))
    else $error("regFile: unknown write data to x%0d", wa);

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module hazardUnit (
  input  riscvPkg::regIdsT  regIds,
  input  logic              loadE,
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              pcSrcE,
  output riscvPkg::hazCtrlT hazCtrl
);
  logic lwStall;

  // Youngest producer first, x0 never forwarded
  function automatic riscvPkg::fwdSelE pickSrc(input logic [`REG_AW-1:0] rs);
    if (rs == '0) begin
      return riscvPkg::fwdNone;
    end else if (regWriteM && rs == regIds.rdM) begin
      return riscvPkg::fwdMem;
    end else if (regWriteW && rs == regIds.rdW) begin
      return riscvPkg::fwdWb;
    end
    return riscvPkg::fwdNone;
  endfunction

  // Load result not ready until writeback of the memory read
  assign lwStall = loadE && ((regIds.rdE == regIds.rs1D) || (regIds.rdE == regIds.rs2D));

  always_comb begin
    hazCtrl.fwdA   = pickSrc(regIds.rs1E);
    hazCtrl.fwdB   = pickSrc(regIds.rs2E);
    hazCtrl.stallF = lwStall;
    hazCtrl.stallD = lwStall;
    hazCtrl.flushD = pcSrcE;                // Wrong-path fetch
    hazCtrl.flushE = lwStall | pcSrcE;      // Bubble or wrong-path decode
  end

  // Load and redirect both live in execute, so they exclude each other
  stallVsBranch: assert final (!(lwStall === 1'b1 && pcSrcE === 1'b1))
    else $error("hazardUnit: load-use stall during taken branch");

endmodule

// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
  input  logic                clk,
  input  logic                reset,
  input  riscvPkg::opcodeE    opD,
  input  logic [2:0]          funct3D,
  input  logic [6:0]          funct7D,
  input  logic                zeroE,
  input  logic                flushE,
  output riscvPkg::immSrcE    immSrcD,
  output riscvPkg::ctrlT      ctrlE,
  output logic                pcSrcE,
  output logic                loadE,      // Load in execute, for stall check
  output logic                memWriteM,
  output logic                regWriteM,
  output logic                regWriteW,
  output riscvPkg::resultSrcE resultSrcW
);
  riscvPkg::ctrlT      ctrlD;
  riscvPkg::aluOpE     aluOpD;
  riscvPkg::resultSrcE resultSrcM;
  logic                subD;

  // funct7[5] means sub only on R-type, addi uses that bit as immediate
  assign subD = (opD == riscvPkg::opRType) && funct7D[5];

  // ========================================================================
  // Decode stage, main decoder then ALU decoder
  // ========================================================================
  always_comb begin
    ctrlD   = '0;
    aluOpD  = riscvPkg::aluAdd;
    immSrcD = riscvPkg::immI;
    case (opD)
      riscvPkg::opLoad: begin
        ctrlD.regWrite  = 1'b1;
        ctrlD.resultSrc = riscvPkg::resMem;
        ctrlD.aluSrc    = 1'b1;            // Base + offset
      end
      riscvPkg::opStore: begin
        ctrlD.memWrite = 1'b1;
        ctrlD.aluSrc   = 1'b1;
        immSrcD        = riscvPkg::immS;
      end
      riscvPkg::opRType: begin
        ctrlD.regWrite = 1'b1;
        aluOpD         = riscvPkg::aluFunct;
      end
      riscvPkg::opIType: begin
        ctrlD.regWrite = 1'b1;
        ctrlD.aluSrc   = 1'b1;
        aluOpD         = riscvPkg::aluFunct;
      end
      riscvPkg::opBranch: begin
        ctrlD.branch = 1'b1;
        aluOpD       = riscvPkg::aluSub;    // Zero flag on equal
        immSrcD      = riscvPkg::immB;
      end
      riscvPkg::opJal: begin
        ctrlD.regWrite  = 1'b1;
        ctrlD.jump      = 1'b1;
        ctrlD.resultSrc = riscvPkg::resPc4; // rd gets PC+4
        immSrcD         = riscvPkg::immJ;
      end
      default: ctrlD = '0;                 // Bubble
    endcase

    // ALU operation
    case (aluOpD)
      riscvPkg::aluSub: ctrlD.aluCtrl = riscvPkg::ctlSub;
      riscvPkg::aluFunct: begin
        case (funct3D)
          3'b000:  ctrlD.aluCtrl = subD ? riscvPkg::ctlSub : riscvPkg::ctlAdd;
          3'b010:  ctrlD.aluCtrl = riscvPkg::ctlSlt; // slt, slti
          3'b110:  ctrlD.aluCtrl = riscvPkg::ctlOr;  // or, ori
          3'b111:  ctrlD.aluCtrl = riscvPkg::ctlAnd; // and, andi
          default: ctrlD.aluCtrl = riscvPkg::ctlAdd;
        endcase
      end
      default: ctrlD.aluCtrl = riscvPkg::ctlAdd;
    endcase
  end

  // ========================================================================
  // Control pipeline, execute then memory and writeback
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrlE <= '0;
    end else if (flushE) begin
      ctrlE <= '0;                         // Kill on redirect or load-use
    end else begin
      ctrlE <= ctrlD;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      resultSrcM <= riscvPkg::resAlu;
      regWriteW  <= 1'b0;
      resultSrcW <= riscvPkg::resAlu;
    end else begin
      regWriteM  <= ctrlE.regWrite;
      memWriteM  <= ctrlE.memWrite;
      resultSrcM <= ctrlE.resultSrc;
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
    end
  end

  // Redirect resolved in execute
  assign pcSrcE = (ctrlE.branch & zeroE) | ctrlE.jump;
  assign loadE  = (ctrlE.resultSrc == riscvPkg::resMem);

  // Fetch only ever hands decode a supported word
  opKnown: assert property (@(posedge clk) disable iff (reset)
    opD inside {riscvPkg::opNop, riscvPkg::opLoad, riscvPkg::opStore,
                riscvPkg::opRType, riscvPkg::opIType, riscvPkg::opBranch,
                riscvPkg::opJal})
    else $error("controlUnit: unknown opcode %b in decode", opD);

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module datapath (
  input  logic                clk,
  input  logic                reset,
  input  logic [`XLEN-1:0]    instrF,
  input  logic [`XLEN-1:0]    readData,
  input  riscvPkg::immSrcE    immSrcD,
  input  riscvPkg::ctrlT      ctrlE,
  input  logic                pcSrcE,
  input  logic                memWriteM,
  input  logic                regWriteW,
  input  riscvPkg::resultSrcE resultSrcW,
  input  riscvPkg::hazCtrlT   hazCtrl,
  output logic [`XLEN-1:0]    pcF,
  output riscvPkg::opcodeE    opD,
  output logic [2:0]          funct3D,
  output logic [6:0]          funct7D,
  output logic                zeroE,
  output riscvPkg::regIdsT    regIds,
  output riscvPkg::dataBusT   dataBus
);
  // Fetch
  logic [`XLEN-1:0]   pcPlus4F;
  // Decode
  logic [`XLEN-1:0]   instrD;
  logic [`XLEN-1:0]   pcD;
  logic [`XLEN-1:0]   pcPlus4D;
  logic [`XLEN-1:0]   rd1D;
  logic [`XLEN-1:0]   rd2D;
  logic [`XLEN-1:0]   immExtD;
  // Execute
  logic [`XLEN-1:0]   rd1E;
  logic [`XLEN-1:0]   rd2E;
  logic [`XLEN-1:0]   pcE;
  logic [`XLEN-1:0]   pcPlus4E;
  logic [`XLEN-1:0]   immExtE;
  logic [`XLEN-1:0]   srcAE;
  logic [`XLEN-1:0]   srcBE;
  logic [`XLEN-1:0]   writeDataE;
  logic [`XLEN-1:0]   aluResultE;
  logic [`XLEN-1:0]   pcTargetE;
  // Memory
  logic [`XLEN-1:0]   aluResultM;
  logic [`XLEN-1:0]   writeDataM;
  logic [`XLEN-1:0]   pcPlus4M;
  // Writeback
  logic [`XLEN-1:0]   aluResultW;
  logic [`XLEN-1:0]   readDataW;
  logic [`XLEN-1:0]   pcPlus4W;
  logic [`XLEN-1:0]   resultW;

  // ========================================================================
  // Fetch
  // ========================================================================
  assign pcPlus4F = pcF + 4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pcF <= `RESET_PC;
    end else if (!hazCtrl.stallF) begin
      pcF <= pcSrcE ? pcTargetE : pcPlus4F; // Redirect from execute
    end
  end

  // ========================================================================
  // Decode
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset || hazCtrl.flushD) begin
      instrD   <= '0;                        // Zero word decodes as bubble
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (!hazCtrl.stallD) begin
      instrD   <= instrF;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign opD         = riscvPkg::opcodeE'(instrD[6:0]);
  assign funct3D     = instrD[14:12];
  assign funct7D     = instrD[31:25];
  assign regIds.rs1D = instrD[19:15];
  assign regIds.rs2D = instrD[24:20];

  regFile regFile0 (
    .clk (clk),
    .we  (regWriteW),
    .ra1 (regIds.rs1D),
    .ra2 (regIds.rs2D),
    .wa  (regIds.rdW),
    .wd  (resultW),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // Immediate extension, sign from bit 31
  always_comb begin
    case (immSrcD)
      riscvPkg::immS: immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      riscvPkg::immB: immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                 instrD[11:8], 1'b0};
      riscvPkg::immJ: immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                 instrD[30:21], 1'b0};
      default:        immExtD = {{20{instrD[31]}}, instrD[31:20]};
    endcase
  end

  // ========================================================================
  // Execute
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset || hazCtrl.flushE) begin
      rd1E        <= '0;
      rd2E        <= '0;
      pcE         <= '0;
      pcPlus4E    <= '0;
      immExtE     <= '0;
      regIds.rs1E <= '0;
      regIds.rs2E <= '0;
      regIds.rdE  <= '0;
    end else begin
      rd1E        <= rd1D;
      rd2E        <= rd2D;
      pcE         <= pcD;
      pcPlus4E    <= pcPlus4D;
      immExtE     <= immExtD;
      regIds.rs1E <= regIds.rs1D;
      regIds.rs2E <= regIds.rs2D;
      regIds.rdE  <= instrD[11:7];
    end
  end

  // Forwarding, memory stage wins over writeback
  always_comb begin
    case (hazCtrl.fwdA)
      riscvPkg::fwdMem: srcAE = aluResultM;
      riscvPkg::fwdWb:  srcAE = resultW;
      default:          srcAE = rd1E;
    endcase
    case (hazCtrl.fwdB)
      riscvPkg::fwdMem: writeDataE = aluResultM;
      riscvPkg::fwdWb:  writeDataE = resultW;
      default:          writeDataE = rd2E;
    endcase
  end

  assign srcBE     = ctrlE.aluSrc ? immExtE : writeDataE;
  assign pcTargetE = pcE + immExtE;          // beq and jal target

  intAlu intAlu0 (
    .a       (srcAE),
    .b       (srcBE),
    .aluCtrl (ctrlE.aluCtrl),
    .result  (aluResultE),
    .zero    (zeroE)
  );

  // ========================================================================
  // Memory and writeback
  // ========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluResultM <= '0;
      writeDataM <= '0;
      pcPlus4M   <= '0;
      regIds.rdM <= '0;
      aluResultW <= '0;
      readDataW  <= '0;
      pcPlus4W   <= '0;
      regIds.rdW <= '0;
    end else begin
      aluResultM <= aluResultE;
      writeDataM <= writeDataE;             // Store data after forwarding
      pcPlus4M   <= pcPlus4E;
      regIds.rdM <= regIds.rdE;
      aluResultW <= aluResultM;
      readDataW  <= readData;
      pcPlus4W   <= pcPlus4M;
      regIds.rdW <= regIds.rdM;
    end
  end

  assign dataBus.addr  = aluResultM;
  assign dataBus.wdata = writeDataM;
  assign dataBus.write = memWriteM;

  always_comb begin
    case (resultSrcW)
      riscvPkg::resMem: resultW = readDataW;
      riscvPkg::resPc4: resultW = pcPlus4W;
      default:          resultW = aluResultW;
    endcase
  end

  // Branch targets and sequential fetch never leave word alignment
  pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
    else $error("datapath: pcF %h not word aligned", pcF);

endmodule

// ==== hdl/riscvCore.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module riscvCore (
  input  logic              clk,
  input  logic              reset,
  output logic [`XLEN-1:0]  pcF,
  input  logic [`XLEN-1:0]  instrF,   // Same-cycle instruction memory read
  output riscvPkg::dataBusT dataBus,
  input  logic [`XLEN-1:0]  readData  // Combinational from dataBus.addr
);
  // Decode fields to control
  riscvPkg::opcodeE    opD;
  logic [2:0]          funct3D;
  logic [6:0]          funct7D;

  // Control to datapath
  riscvPkg::immSrcE    immSrcD;
  riscvPkg::ctrlT      ctrlE;
  logic                pcSrcE;       // Taken beq or jal
  logic                zeroE;
  logic                loadE;
  logic                memWriteM;
  logic                regWriteM;
  logic                regWriteW;
  riscvPkg::resultSrcE resultSrcW;

  // Hazard traffic
  riscvPkg::regIdsT    regIds;
  riscvPkg::hazCtrlT   hazCtrl;

  controlUnit controlUnit0 (
    .clk        (clk),
    .reset      (reset),
    .opD        (opD),
    .funct3D    (funct3D),
    .funct7D    (funct7D),
    .zeroE      (zeroE),
    .flushE     (hazCtrl.flushE),
    .immSrcD    (immSrcD),
    .ctrlE      (ctrlE),
    .pcSrcE     (pcSrcE),
    .loadE      (loadE),
    .memWriteM  (memWriteM),
    .regWriteM  (regWriteM),
    .regWriteW  (regWriteW),
    .resultSrcW (resultSrcW)
  );

  datapath datapath0 (
    .clk        (clk),
    .reset      (reset),
    .instrF     (instrF),
    .readData   (readData),
    .immSrcD    (immSrcD),
    .ctrlE      (ctrlE),
    .pcSrcE     (pcSrcE),
    .memWriteM  (memWriteM),
    .regWriteW  (regWriteW),
    .resultSrcW (resultSrcW),
    .hazCtrl    (hazCtrl),
    .pcF        (pcF),
    .opD        (opD),
    .funct3D    (funct3D),
    .funct7D    (funct7D),
    .zeroE      (zeroE),
    .regIds     (regIds),
    .dataBus    (dataBus)
  );

  hazardUnit hazardUnit0 (
    .regIds    (regIds),
    .loadE     (loadE),
    .regWriteM (regWriteM),
    .regWriteW (regWriteW),
    .pcSrcE    (pcSrcE),
    .hazCtrl   (hazCtrl)
  );

endmodule

// ==== bench/coreBench.sv ====
`timescale 1ns/1ps
`include "riscv_defs.svh"

module coreBench;

  // Instruction kinds of the generator and reference model
  localparam int kAdd  = 0;
  localparam int kSub  = 1;
  localparam int kAnd  = 2;
  localparam int kOr   = 3;
  localparam int kSlt  = 4;
  localparam int kAddi = 5;
  localparam int kAndi = 6;
  localparam int kOri  = 7;
  localparam int kSlti = 8;
  localparam int kLw   = 9;
  localparam int kSw   = 10;
  localparam int kBeq  = 11;
  localparam int kJal  = 12;   // Last kind, also the random range

  localparam int numPrograms = 24;
  localparam int dumpBase    = 224;  // x1..x7 dumped to words 56..62

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  logic [`XLEN-1:0]  pcOut;
  logic [`XLEN-1:0]  instrIn;
  logic [`XLEN-1:0]  readIn;
  riscvPkg::dataBusT busOut;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] dmemInit [64];  // Loaded into dmem while reset is high

  // Program as generated, one entry per instruction
  int progKind [64];
  int progRd   [64];
  int progRs1  [64];
  int progRs2  [64];
  int progImm  [64];
  int progLen;

  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int          seenCount;
  int          storeErrs = 0;
  int          extraStores = 0;
  int          miscErrs = 0;

  always #2 clk = ~clk;        // 4 ns period

  riscvCore dut0 (
    .clk      (clk),
    .reset    (reset),
    .pcF      (pcOut),
    .instrF   (instrIn),
    .dataBus  (busOut),
    .readData (readIn)
  );

  // ========================================================================
  // Memories, both reads combinational
  // ========================================================================
  assign instrIn = imem[pcOut[7:2]];
  assign readIn  = dmem[busOut.addr[7:2]];

  always @(posedge clk) begin : dataMem
    if (reset) begin
      for (int w = 0; w < 64; w++) begin
        dmem[w] <= dmemInit[w];
      end
    end else if (busOut.write === 1'b1) begin
      dmem[busOut.addr[7:2]] <= busOut.wdata;
    end
  end

  // ========================================================================
  // Program generation
  // ========================================================================
  function automatic logic [31:0] encode(input int kind, input int rd, input int rs1,
                                         input int rs2, input int imm);
    logic [31:0] i;
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    i  = imm;
    d  = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    case (kind)
      kAdd:    return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
      kSub:    return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
      kAnd:    return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
      kOr:     return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
      kSlt:    return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
      kAddi:   return {i[11:0], s1, 3'b000, d, 7'b0010011};
      kAndi:   return {i[11:0], s1, 3'b111, d, 7'b0010011};
      kOri:    return {i[11:0], s1, 3'b110, d, 7'b0010011};
      kSlti:   return {i[11:0], s1, 3'b010, d, 7'b0010011};
      kLw:     return {i[11:0], s1, 3'b010, d, 7'b0000011};
      kSw:     return {i[11:5], s2, s1, 3'b010, i[4:0], 7'b0100011};
      kBeq:    return {i[12], i[10:5], s2, s1, 3'b000, i[4:1], i[11], 7'b1100011};
      default: return {i[20], i[10:1], i[11], i[19:12], d, 7'b1101111}; // jal
    endcase
  endfunction

  function automatic void addInstr(input int kind, input int rd, input int rs1,
                                   input int rs2, input int imm);
    progKind[progLen] = kind;
    progRd[progLen]   = rd;
    progRs1[progLen]  = rs1;
    progRs2[progLen]  = rs2;
    progImm[progLen]  = imm;
    imem[progLen]     = encode(kind, rd, rs1, rs2, imm);
    progLen++;
  endfunction

  function automatic int randImm12();
    int v;
    v = $urandom_range(4095);
    return v - 2048;           // Signed 12-bit range
  endfunction

  function automatic void buildProgram();
    int bodyLen;
    int dumpAt;
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    int loadRd;
    progLen = 0;
    loadRd  = 0;
    for (int a = 0; a < 64; a++) begin
      imem[a] = '0;            // Bubble words past the end
    end
    // Known register state first, the register file has no reset
    for (int r = 1; r <= 7; r++) begin
      addInstr(kAddi, r, 0, 0, randImm12());
    end
    bodyLen = 8 + $urandom_range(25);
    dumpAt  = 7 + bodyLen;
    while (progLen < dumpAt) begin
      kind = $urandom_range(kJal);
      rd   = $urandom_range(7);  // x0 included, writes must vanish
      rs1  = $urandom_range(7);
      rs2  = $urandom_range(7);
      imm  = randImm12();
      if (loadRd != 0 && $urandom_range(1) == 1) begin
        rs1 = loadRd;          // Use right after a load
      end
      case (kind)
        kLw, kSw: begin
          rs1 = 0;
          imm = 4 * $urandom_range(63);
        end
        kBeq, kJal: begin
          if (kind == kBeq && $urandom_range(1) == 1) begin
            rs2 = rs1;         // Forces a taken beq
          end
          imm = 1 + $urandom_range(2);
          if (progLen + imm > dumpAt) begin
            imm = dumpAt - progLen;  // Never past the dump
          end
          imm = imm * 4;
        end
        default: ;
      endcase
      loadRd = (kind == kLw) ? rd : 0;
      addInstr(kind, rd, rs1, rs2, imm);
    end
    for (int r = 1; r <= 7; r++) begin
      addInstr(kSw, 0, 0, r, dumpBase + 4 * (r - 1));
    end
    addInstr(kJal, 0, 0, 0, 0); // Spin in place
  endfunction

  // ========================================================================
  // Reference ISA model, one instruction at a time
  // ========================================================================
  function automatic void runReference();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immV;
    logic [31:0] res;
    logic [31:0] addr;
    int          pc;
    int          next;
    int          steps;
    bit          writes;
    expAddr.delete();
    expData.delete();
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int w = 0; w < 64; w++) begin
      mem[w] = dmemInit[w];
    end
    pc    = 0;
    steps = 0;
    while (pc != progLen - 1 && steps < 400) begin
      a      = regs[progRs1[pc]];
      b      = regs[progRs2[pc]];
      immV   = progImm[pc];
      addr   = a + immV;
      res    = '0;
      writes = 1'b1;
      next   = pc + 1;
      case (progKind[pc])
        kAdd:  res = a + b;
        kSub:  res = a - b;
        kAnd:  res = a & b;
        kOr:   res = a | b;
        kSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        kAddi: res = a + immV;
        kAndi: res = a & immV;
        kOri:  res = a | immV;
        kSlti: res = ($signed(a) < $signed(immV)) ? 32'd1 : 32'd0;
        kLw:   res = mem[addr[7:2]];
        kSw: begin
          writes = 1'b0;
          mem[addr[7:2]] = b;
          expAddr.push_back(addr);
          expData.push_back(b);
        end
        kBeq: begin
          writes = 1'b0;
          if (a == b) begin
            next = pc + progImm[pc] / 4;
          end
        end
        default: begin         // jal links PC+4
          res  = (pc + 1) * 4;
          next = pc + progImm[pc] / 4;
        end
      endcase
      if (writes && progRd[pc] != 0) begin
        regs[progRd[pc]] = res;
      end
      pc = next;
      steps++;
    end
  endfunction

  // ========================================================================
  // Store checker
  // ========================================================================
  always @(posedge clk) begin : storeCheck
    if (reset) begin
      seenCount <= 0;
      if (busOut.write === 1'b1) begin
        extraStores++;
        $display("Store issued while reset is asserted, address %h", busOut.addr);
      end
    end else if (busOut.write === 1'b1) begin
      if (seenCount >= expAddr.size()) begin
        extraStores++;
        $display("Unexpected store to address %h beyond the %0d expected stores",
                 busOut.addr, expAddr.size());
      end else begin
        assert (busOut.addr === expAddr[seenCount]) else begin
          storeErrs++;
          $display("ERR dataBus.addr store %0d: expected %h, got %h",
                   seenCount, expAddr[seenCount], busOut.addr);
        end
        assert (busOut.wdata === expData[seenCount]) else begin
          storeErrs++;
          $display("ERR dataBus.wdata store %0d: expected %h, got %h",
                   seenCount, expData[seenCount], busOut.wdata);
        end
        seenCount <= seenCount + 1;
      end
    end
  end

  // ========================================================================
  // Run control
  // ========================================================================
  task automatic runProgram(input int progNum, output bit timedOut);
    int cycles;
    int idle;
    int limit;
    timedOut = 1'b0;
    @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    buildProgram();
    for (int w = 0; w < 64; w++) begin
      dmemInit[w] = $urandom();
    end
    runReference();
    limit = 16 + 4 * progLen + 20;
    repeat (16) @(posedge clk);
    reset  <= 1'b0;
    cycles = 16;
    @(negedge clk);
    // First fetch after reset is word 0
    assert (pcOut === 32'h0000_0000) else begin
      miscErrs++;
      $display("ERR pcF first fetch: expected %h, got %h", 32'h0000_0000, pcOut);
    end
    idle = 0;
    while (idle < 10 && cycles < limit) begin
      @(posedge clk);
      cycles++;
      if (seenCount >= expAddr.size()) begin
        idle++;                // Quiet tail after the last store
      end
    end
    if (idle < 10) begin
      timedOut = 1'b1;
      miscErrs++;
      $display("Timeout in program %0d, %0d of %0d stores seen after %0d cycles",
               progNum, seenCount, expAddr.size(), cycles);
    end
  endtask

  task automatic finishRun();
    $display("Errors: %0d store mismatches, %0d unexpected stores, %0d other",
             storeErrs, extraStores, miscErrs);
    if (storeErrs + extraStores + miscErrs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  initial begin : mainFlow
    bit timedOut;
    timedOut = 1'b0;
    void'($urandom(8665));
    for (int w = 0; w < 64; w++) begin
      imem[w] = '0;
    end
    for (int p = 0; p < numPrograms && !timedOut; p++) begin
      runProgram(p, timedOut);
    end
    finishRun();
  end

endmodule

// ==== riscvCore.f ====
+incdir+include
hdl/riscvPkg.sv
hdl/intAlu.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/controlUnit.sv
hdl/datapath.sv
hdl/riscvCore.sv
bench/coreBench.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build coreBench with Verilator, run it, then scan the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module coreBench -f riscvCore.f \
  > build.log 2>&1 \
  && ./obj_dir/VcoreBench > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Test FAILED" sim.log \
  && { echo "Simulation reported failures, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
